// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP ?= tb_if_id_stage
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the log decides the result, not the simulator exit status
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/decoded_instr_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface decoded_instr_if
	import if_id_pkg::*;
();

	// fields of the word currently on the cache bus
	decoded_instr_t instr;
	// control-flow word that is not a nop
	logic changes_pc;
	logic nop;

	modport source
	(
		output instr,
		output changes_pc,
		output nop
	);

	modport sink
	(
		input instr,
		input changes_pc,
		input nop
	);

endinterface

`default_nettype wire

// ==== hw/fetch_control.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "if_id_cfg.svh"

module fetch_control
	import if_id_pkg::*;
(
	input logic clk,
	input logic reset,

	// decoded cache word
	decoded_instr_if.sink dec,
	input logic icache_valid,

	// execute and writeback feedback
	input logic ex_stall,
	input cpu_addr_t ex_computed_pc,
	input logic wb_stall,

	// instruction cache request
	output logic icache_req,
	output cpu_addr_t icache_addr,

	// issue register to execute
	output decoded_instr_t ex_instr,
	output cpu_addr_t ex_pc,

	// register indices for the control unit
	output reg_index_t ctrl_ra_index,
	output reg_index_t ctrl_rb_index,
	output reg_index_t ctrl_rc_index
);

	fetch_state_t state;
	fetch_state_t state_next;

	// speculative program counter
	cpu_addr_t pc;
	cpu_addr_t pc_next;
	cpu_addr_t following_pc;

	decoded_instr_t instr_next;
	cpu_addr_t issue_pc_next;
	logic word_taken;

	assign following_pc = pc + cpu_addr_t'(`IF_ID_INSTR_BYTES);

	// valid word that execute can accept now
	assign word_taken = icache_valid && !ex_stall;

	always_comb
	begin
		state_next = state;
		pc_next = pc;
		instr_next = ex_instr;
		issue_pc_next = ex_pc;
		icache_req = 1'b1;

		case (state)
		st_init:
		begin
			// first word seen, pc stays at 0
			instr_next = instr_bubble;
			if (icache_valid)
			begin
				state_next = st_regular;
			end
		end

		st_regular:
		begin
			// no further fetch until the branch target is known
			if (icache_valid && dec.changes_pc)
			begin
				icache_req = 1'b0;
			end

			if (!icache_valid)
			begin
				instr_next = instr_bubble;
			end
			else if (word_taken)
			begin
				pc_next = following_pc;
				if (dec.nop)
				begin
					instr_next = instr_bubble;
				end
				else
				begin
					instr_next = dec.instr;
					case (dec.instr.group)
					group_ctrl_flow:
					begin
						// execute computes the target relative to pc+4
						issue_pc_next = following_pc;
						state_next = st_change_pc;
					end
					group_load, group_store:
					begin
						issue_pc_next = pc;
						state_next = st_wait_ldst_0;
					end
					default:
					begin
						issue_pc_next = pc;
					end
					endcase
				end
			end
			// otherwise back-pressure holds the issue register
		end

		st_change_pc:
		begin
			pc_next = ex_computed_pc;
			instr_next = instr_bubble;
			state_next = st_regular;
		end

		st_wait_ldst_0:
		begin
			instr_next = instr_bubble;
			state_next = st_wait_ldst_1;
		end

		st_wait_ldst_1:
		begin
			instr_next = instr_bubble;
			if (!wb_stall)
			begin
				state_next = st_regular;
			end
		end

		default:
		begin
			instr_next = instr_bubble;
			state_next = st_init;
		end
		endcase
	end

	// request always targets the pc held next cycle
	assign icache_addr = pc_next;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_init;
			pc <= '0;
			ex_instr <= instr_bubble;
			ex_pc <= '0;
		end
		else
		begin
			state <= state_next;
			pc <= pc_next;
			ex_instr <= instr_next;
			ex_pc <= issue_pc_next;
		end
	end

	// indices only meaningful while decoding live words
	always_comb
	begin
		if (state == st_regular)
		begin
			ctrl_ra_index = dec.instr.ra_index;
			ctrl_rb_index = dec.instr.rb_index;
			ctrl_rc_index = dec.instr.rc_index;
		end
		else
		begin
			ctrl_ra_index = '0;
			ctrl_rb_index = '0;
			ctrl_rc_index = '0;
		end
	end

endmodule

`default_nettype wire

// ==== hw/if_id_cfg.svh ====
`ifndef IF_ID_CFG_SVH
`define IF_ID_CFG_SVH

// raw instruction word
`define IF_ID_INSTR_WIDTH 32

// cpu byte address
`define IF_ID_ADDR_WIDTH 32

// immediate after sign extension
`define IF_ID_DATA_WIDTH 64

// register file index
`define IF_ID_REG_INDEX_WIDTH 4

// pc step per instruction
`define IF_ID_INSTR_BYTES 4

`endif

// ==== hw/if_id_pkg.sv ====
`default_nettype none

`include "if_id_cfg.svh"

package if_id_pkg;

	typedef logic [`IF_ID_ADDR_WIDTH-1:0] cpu_addr_t;
	typedef logic [`IF_ID_INSTR_WIDTH-1:0] instr_word_t;
	typedef logic [`IF_ID_REG_INDEX_WIDTH-1:0] reg_index_t;

	// instruction class from the top two bits
	typedef enum logic [1:0]
	{
		group_alu = 2'd0,
		group_ctrl_flow = 2'd1,
		group_load = 2'd2,
		group_store = 2'd3
	} instr_group_t;

	typedef enum logic [2:0]
	{
		st_init,
		st_regular,
		st_change_pc,
		st_wait_ldst_0,
		st_wait_ldst_1
	} fetch_state_t;

	// record handed to the execute stage
	typedef struct packed
	{
		instr_group_t group;
		logic [3:0] oper;
		logic op_type;
		reg_index_t ra_index;
		reg_index_t rb_index;
		reg_index_t rc_index;
		logic [`IF_ID_DATA_WIDTH-1:0] signext_imm;
		logic nop;
	} decoded_instr_t;

	// all zero means nothing issued this cycle
	localparam decoded_instr_t instr_bubble = '0;

endpackage

`default_nettype wire

// ==== hw/if_id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module if_id_stage
	import if_id_pkg::*;
(
	input logic clk,
	input logic reset,

	// instruction cache
	input logic icache_valid,
	input instr_word_t icache_instr,
	output logic icache_req,
	output cpu_addr_t icache_addr,

	// execute stage
	input logic ex_stall,
	input cpu_addr_t ex_computed_pc,
	output decoded_instr_t ex_instr,
	output cpu_addr_t ex_pc,

	// writeback stage
	input logic wb_stall,

	// control unit
	output reg_index_t ctrl_ra_index,
	output reg_index_t ctrl_rb_index,
	output reg_index_t ctrl_rc_index
);

	decoded_instr_if dec_bus ();

	instr_decoder decoder_i
	(
		.instr(icache_instr),
		.dec(dec_bus.source)
	);

	fetch_control control_i
	(
		.clk(clk),
		.reset(reset),
		.dec(dec_bus.sink),
		.icache_valid(icache_valid),
		.ex_stall(ex_stall),
		.ex_computed_pc(ex_computed_pc),
		.wb_stall(wb_stall),
		.icache_req(icache_req),
		.icache_addr(icache_addr),
		.ex_instr(ex_instr),
		.ex_pc(ex_pc),
		.ctrl_ra_index(ctrl_ra_index),
		.ctrl_rb_index(ctrl_rb_index),
		.ctrl_rc_index(ctrl_rc_index)
	);

endmodule

`default_nettype wire

// ==== hw/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "if_id_cfg.svh"

module instr_decoder
	import if_id_pkg::*;
(
	input instr_word_t instr,
	decoded_instr_if.source dec
);

	localparam int imm12_width = 12;
	localparam int imm20_width = 20;

	decoded_instr_t fields;
	logic [imm12_width-1:0] imm12;
	logic [imm20_width-1:0] imm20;
	logic is_nop;

	assign imm12 = instr[imm12_width-1:0];
	assign imm20 = instr[imm20_width-1:0];

	// bit 24 marks an explicit nop
	assign is_nop = (instr == '0) || instr[24];

	always_comb
	begin
		fields.group = instr_group_t'(instr[31:30]);
		fields.oper = instr[29:26];
		fields.op_type = instr[25];
		fields.ra_index = instr[23:20];
		fields.rb_index = instr[19:16];
		fields.rc_index = instr[15:12];
		fields.nop = is_nop;

		// branches carry the wide offset, others the short one
		if (fields.group == group_ctrl_flow)
		begin
			fields.signext_imm = {{(`IF_ID_DATA_WIDTH - imm20_width){imm20[imm20_width-1]}},
				imm20};
		end
		else
		begin
			fields.signext_imm = {{(`IF_ID_DATA_WIDTH - imm12_width){imm12[imm12_width-1]}},
				imm12};
		end
	end

	assign dec.instr = fields;
	assign dec.nop = is_nop;
	assign dec.changes_pc = (fields.group == group_ctrl_flow) && !is_nop;

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hw
hw/if_id_pkg.sv
hw/decoded_instr_if.sv
hw/instr_decoder.sv
hw/fetch_control.sv
hw/if_id_stage.sv
verif/tb_if_id_stage.sv

// ==== verif/tb_if_id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "if_id_cfg.svh"

module tb_if_id_stage
	import if_id_pkg::*;
();

	localparam int target_issues = 400;
	localparam int max_cycles = 20000;

	logic clk = 1'b0;
	logic reset;
	logic icache_valid;
	instr_word_t icache_instr;
	logic ex_stall;
	cpu_addr_t ex_computed_pc;
	logic wb_stall;
	logic icache_req;
	cpu_addr_t icache_addr;
	decoded_instr_t ex_instr;
	cpu_addr_t ex_pc;
	reg_index_t ctrl_ra_index;
	reg_index_t ctrl_rb_index;
	reg_index_t ctrl_rc_index;

	integer seed = 32'h972c_f4f0;
	instr_word_t mem [0:255];

	// request as seen by the cache model
	logic req_q = 1'b0;
	cpu_addr_t addr_q = '0;

	// reference model of the stage
	fetch_state_t m_state;
	cpu_addr_t m_pc;
	decoded_instr_t exp_instr;
	cpu_addr_t exp_ipc;

	int errors = 0;
	int checks = 0;
	int issued = 0;
	int branches = 0;
	int ldst = 0;

	if_id_stage dut_i
	(
		.clk(clk),
		.reset(reset),
		.icache_valid(icache_valid),
		.icache_instr(icache_instr),
		.icache_req(icache_req),
		.icache_addr(icache_addr),
		.ex_stall(ex_stall),
		.ex_computed_pc(ex_computed_pc),
		.ex_instr(ex_instr),
		.ex_pc(ex_pc),
		.wb_stall(wb_stall),
		.ctrl_ra_index(ctrl_ra_index),
		.ctrl_rb_index(ctrl_rb_index),
		.ctrl_rc_index(ctrl_rc_index)
	);

	initial
	begin
		forever #50 clk = ~clk;
	end

	task automatic compare_instr(input string name, input decoded_instr_t exp,
		input decoded_instr_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic compare_addr(input string name, input cpu_addr_t exp, input cpu_addr_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic compare_index(input string name, input reg_index_t exp, input reg_index_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("mismatch %s expected %b actual %b", name, exp, act);
		end
	endtask

	// field split straight from the encoding table
	function automatic decoded_instr_t decode_word(input instr_word_t w);
		decoded_instr_t d;
		d.group = instr_group_t'(w[31:30]);
		d.oper = w[29:26];
		d.op_type = w[25];
		d.ra_index = w[23:20];
		d.rb_index = w[19:16];
		d.rc_index = w[15:12];
		if (w[31:30] == 2'd1)
			d.signext_imm = {{44{w[19]}}, w[19:0]};
		else
			d.signext_imm = {{52{w[11]}}, w[11:0]};
		d.nop = (w == '0) || w[24];
		return d;
	endfunction

	// mix of alu, nop, branch and load/store words
	task automatic fill_program();
		logic [31:0] w;
		logic [31:0] k;
		for (int i = 0; i < 256; i++)
		begin
			w = $random(seed);
			k = $random(seed);
			w[24] = 1'b0;
			case (k[3:0])
			4'd0: w = '0;
			4'd1: w[24] = 1'b1;
			4'd2, 4'd3: w[31:30] = 2'd1;
			4'd4, 4'd5: w[31:30] = 2'd2;
			4'd6: w[31:30] = 2'd3;
			default: w[31:30] = 2'd0;
			endcase
			mem[i] = w;
		end
	endtask

	// cache answers and random execute/writeback feedback
	always @(posedge clk)
	begin
		logic [31:0] r;
		r = $random(seed);
		icache_valid <= req_q && (r[1:0] != 2'd0);
		icache_instr <= mem[addr_q[9:2]];
		ex_stall <= (r[3:2] == 2'd0);
		wb_stall <= r[4];
		ex_computed_pc <= {22'd0, r[15:8], 2'b00};
	end

	// checks and model step at mid cycle
	always @(negedge clk)
	begin
		decoded_instr_t d;
		decoded_instr_t n_instr;
		cpu_addr_t n_pc;
		cpu_addr_t n_ipc;
		fetch_state_t n_state;
		logic exp_req;

		req_q <= icache_req;
		addr_q <= icache_addr;
		if (reset)
		begin
			m_state = st_init;
			m_pc = '0;
			exp_instr = '0;
			exp_ipc = '0;
			compare_instr("reset ex_instr", '0, ex_instr);
			compare_addr("reset ex_pc", '0, ex_pc);
			compare_flag("reset icache_req", 1'b1, icache_req);
			compare_addr("reset icache_addr", '0, icache_addr);
			compare_index("reset ctrl_ra_index", '0, ctrl_ra_index);
			compare_index("reset ctrl_rb_index", '0, ctrl_rb_index);
			compare_index("reset ctrl_rc_index", '0, ctrl_rc_index);
		end
		else
		begin
			d = decode_word(mem[m_pc[9:2]]);
			n_state = m_state;
			n_pc = m_pc;
			n_instr = exp_instr;
			n_ipc = exp_ipc;
			exp_req = 1'b1;
			compare_instr("issue record", exp_instr, ex_instr);
			compare_addr("issue pc", exp_ipc, ex_pc);

			case (m_state)
			st_init:
			begin
				n_instr = '0;
				if (icache_valid)
					n_state = st_regular;
			end
			st_regular:
			begin
				if (icache_valid)
				begin
					compare_index("ctrl_ra_index", d.ra_index, ctrl_ra_index);
					compare_index("ctrl_rb_index", d.rb_index, ctrl_rb_index);
					compare_index("ctrl_rc_index", d.rc_index, ctrl_rc_index);
					// fetch pauses behind a live branch
					if (d.group == group_ctrl_flow && !d.nop)
						exp_req = 1'b0;
				end
				if (!icache_valid)
					n_instr = '0;
				else if (!ex_stall)
				begin
					n_pc = m_pc + `IF_ID_INSTR_BYTES;
					if (d.nop)
						n_instr = '0;
					else
					begin
						issued++;
						n_instr = d;
						n_ipc = m_pc;
						case (d.group)
						group_ctrl_flow:
						begin
							branches++;
							n_ipc = m_pc + `IF_ID_INSTR_BYTES;
							n_state = st_change_pc;
						end
						group_load, group_store:
						begin
							ldst++;
							n_state = st_wait_ldst_0;
						end
						default:
						begin
							n_state = st_regular;
						end
						endcase
					end
				end
			end
			st_change_pc:
			begin
				// branch target is whatever execute shows now
				n_pc = ex_computed_pc;
				n_instr = '0;
				n_state = st_regular;
			end
			st_wait_ldst_0:
			begin
				n_instr = '0;
				n_state = st_wait_ldst_1;
			end
			st_wait_ldst_1:
			begin
				n_instr = '0;
				if (!wb_stall)
					n_state = st_regular;
			end
			endcase

			compare_flag("icache_req", exp_req, icache_req);
			if (exp_req)
				compare_addr("icache_addr", n_pc, icache_addr);
			if (m_state != st_regular)
			begin
				compare_index("idle ctrl_ra_index", '0, ctrl_ra_index);
				compare_index("idle ctrl_rb_index", '0, ctrl_rb_index);
				compare_index("idle ctrl_rc_index", '0, ctrl_rc_index);
			end

			m_state = n_state;
			m_pc = n_pc;
			exp_instr = n_instr;
			exp_ipc = n_ipc;
		end
	end

	initial
	begin
		int cycles;
		fill_program();
		reset = 1'b1;
		icache_valid = 1'b0;
		icache_instr = '0;
		ex_stall = 1'b0;
		ex_computed_pc = '0;
		wb_stall = 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		cycles = 0;
		while (issued < target_issues && cycles < max_cycles)
		begin
			@(posedge clk);
			cycles++;
		end
		if (issued < target_issues)
		begin
			errors++;
			$display("timeout: only %0d instructions issued in %0d cycles", issued, cycles);
		end

		$display("checks %0d errors %0d issued %0d branches %0d loads/stores %0d",
			checks, errors, issued, branches, ldst);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
